//--- verif/board_top_testdata.txt
// expected raw command words in send order, one hex word per line
// then the number of boot requests, then icap_avail low cycles before each request may start
FFFFFFFF
AA995566
20000000
30008001
0000000F
20000000
// boot requests to run
00000003
// icap_avail low cycles, one entry per request
00000000
00000000
0000003C

//--- all.f
source/boot_cfg_pkg.sv
source/board_pkg.sv
source/signal_sync.sv
source/icap_reboot_seq.sv
source/flash_pin_stage.sv
source/board_top.sv
verif/board_top_checker.sv
verif/board_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds board_top_tb with Verilator, runs it and judges the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module board_top_tb -o board_top_sim -f all.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/board_top_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "result: fail"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "result: run ended without a verdict"; exit 1; }
echo "result: pass"

//--- verif/board_top_tb.sv
// testbench for board_top, runs boot requests from the data file and random flash pin traffic
`timescale 1ns/1ns

module board_top_tb
    import boot_cfg_pkg::*;
    import board_pkg::*;
();

    localparam int CLK_HALF_NS = 4;
    localparam int RESET_CYCLES = 16;
    localparam int DATA_WORDS = 10;
    // request count follows the six command words
    localparam int REQ_COUNT_IDX = CFG_SEQ_LEN;
    localparam int START_TIMEOUT = 50;
    localparam int ACK_TIMEOUT = 20;
    localparam int FLASH_CYCLES = 64;
    // controller at rest, chip deselected and lines released
    localparam qspi_ctrl_t IDLE_CTRL = '{clk: 1'b0, cs: 1'b1, dq_o: 4'h0, dq_oe: 4'h0};
    // controller active while reset is held
    localparam qspi_ctrl_t RESET_CTRL = '{clk: 1'b1, cs: 1'b0, dq_o: 4'h0, dq_oe: 4'hF};

    logic       clk_125mhz_int;
    logic       reset;
    logic       boot_req;
    logic       boot_ack;
    logic       icap_avail;
    logic       icap_csib;
    logic       icap_rdwrb;
    cfg_word_t  icap_di;
    qspi_ctrl_t qspi_ctrl;
    qspi_pin_t  qspi_pins;
    qspi_dq_t   qspi_dq_pin;
    qspi_dq_t   qspi_dq_i;

    logic [31:0] testdata [0:DATA_WORDS-1];
    logic [31:0] lcg_state;
    int          value_errors;
    int          timeout_errors;

    board_top board_top_i (
        .clk_125mhz_int(clk_125mhz_int),
        .reset(reset),
        .boot_req(boot_req),
        .boot_ack(boot_ack),
        .icap_avail(icap_avail),
        .icap_csib(icap_csib),
        .icap_rdwrb(icap_rdwrb),
        .icap_di(icap_di),
        .qspi_ctrl(qspi_ctrl),
        .qspi_pins(qspi_pins),
        .qspi_dq_pin(qspi_dq_pin),
        .qspi_dq_i(qspi_dq_i)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever begin
            #CLK_HALF_NS clk_125mhz_int = ~clk_125mhz_int;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // bit i trades places with bit 7-i
    function automatic logic [7:0] mirror_byte(input logic [7:0] b);
        logic [7:0] m;
        for (int i = 0; i < 8; i++) begin
            m[i] = b[7 - i];
        end
        return m;
    endfunction

    // byte order stays, bits inside each byte flip
    function automatic cfg_word_t port_word(input cfg_word_t w);
        return {mirror_byte(w[31:24]), mirror_byte(w[23:16]),
                mirror_byte(w[15:8]), mirror_byte(w[7:0])};
    endfunction

    function automatic qspi_pin_t expected_pins(input qspi_ctrl_t c);
        qspi_pin_t p;
        p.clk = c.clk;
        p.cs = c.cs;
        p.dq_o = c.dq_o;
        p.dq_ts = ~c.dq_oe;
        return p;
    endfunction

    task automatic check_word(input string name, input cfg_word_t exp, input cfg_word_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_pins(input string name, input qspi_pin_t exp, input qspi_pin_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_dq(input string name, input qspi_dq_t exp, input qspi_dq_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    // one full req/ack round, port kept busy for avail_delay cycles first
    task automatic boot_handshake(input int req_idx, input int avail_delay);
        int    waited;
        string name;
        name = $sformatf("boot%0d", req_idx);
        @(posedge clk_125mhz_int);
        boot_req <= 1'b1;
        icap_avail <= (avail_delay == 0);
        for (int c = 0; c < avail_delay; c++) begin
            @(negedge clk_125mhz_int);
            check_bit($sformatf("%s csib while busy", name), 1'b1, icap_csib);
        end
        if (avail_delay > 0) begin
            @(posedge clk_125mhz_int);
            icap_avail <= 1'b1;
        end
        waited = 0;
        @(negedge clk_125mhz_int);
        while (icap_csib !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clk_125mhz_int);
            waited++;
        end
        if (icap_csib !== 1'b0) begin
            $display("ERROR %s: icap_csib never went low after the boot request", name);
            timeout_errors++;
            @(posedge clk_125mhz_int);
            boot_req <= 1'b0;
            return;
        end
        for (int k = 0; k < CFG_SEQ_LEN; k++) begin
            check_bit($sformatf("%s csib word%0d", name, k), 1'b0, icap_csib);
            check_word($sformatf("%s word%0d", name, k), port_word(testdata[k]), icap_di);
            @(negedge clk_125mhz_int);
        end
        // port released and ack raised in the same cycle
        check_bit($sformatf("%s csib after", name), 1'b1, icap_csib);
        check_word($sformatf("%s word after", name), '1, icap_di);
        check_bit($sformatf("%s ack rise", name), 1'b1, boot_ack);
        @(posedge clk_125mhz_int);
        boot_req <= 1'b0;
        waited = 0;
        @(negedge clk_125mhz_int);
        while (boot_ack !== 1'b0 && waited < ACK_TIMEOUT) begin
            check_bit($sformatf("%s csib in release", name), 1'b1, icap_csib);
            @(negedge clk_125mhz_int);
            waited++;
        end
        if (boot_ack !== 1'b0) begin
            $display("ERROR %s: boot_ack did not fall after boot_req was lowered", name);
            timeout_errors++;
        end
    endtask

    // pins one cycle behind the controller, data lines two behind the pins
    task automatic flash_traffic();
        qspi_ctrl_t  ctrl_hist [0:FLASH_CYCLES-1];
        qspi_dq_t    dq_hist [0:FLASH_CYCLES-1];
        logic [31:0] rnd;
        for (int i = 0; i < FLASH_CYCLES; i++) begin
            rnd = next_random();
            ctrl_hist[i] = qspi_ctrl_t'(rnd[25:16]);
            dq_hist[i] = rnd[29:26];
            @(posedge clk_125mhz_int);
            qspi_ctrl <= ctrl_hist[i];
            qspi_dq_pin <= dq_hist[i];
            @(negedge clk_125mhz_int);
            if (i >= 1) begin
                check_pins($sformatf("flash pins %0d", i), expected_pins(ctrl_hist[i - 1]),
                           qspi_pins);
            end
            if (i >= 2) begin
                check_dq($sformatf("flash dq %0d", i), dq_hist[i - 2], qspi_dq_i);
            end
        end
    endtask

    initial begin
        int req_count;
        lcg_state = 32'd66;
        value_errors = 0;
        timeout_errors = 0;
        reset <= 1'b1;
        boot_req <= 1'b0;
        icap_avail <= 1'b0;
        qspi_ctrl <= RESET_CTRL;
        qspi_dq_pin <= '1;
        $readmemh("verif/board_top_testdata.txt", testdata);
        repeat (RESET_CYCLES) @(posedge clk_125mhz_int);
        reset <= 1'b0;
        qspi_ctrl <= IDLE_CTRL;
        qspi_dq_pin <= '0;
        @(negedge clk_125mhz_int);

        check_bit("reset csib", 1'b1, icap_csib);
        check_bit("reset rdwrb", 1'b0, icap_rdwrb);
        check_word("reset word", '1, icap_di);
        check_bit("reset ack", 1'b0, boot_ack);
        check_pins("reset pins", expected_pins(IDLE_CTRL), qspi_pins);
        check_dq("reset dq", '0, qspi_dq_i);

        req_count = int'(testdata[REQ_COUNT_IDX]);
        if (req_count > DATA_WORDS - REQ_COUNT_IDX - 1) begin
            $display("ERROR the data file asks for more boot requests than it has delays for");
            timeout_errors++;
            req_count = DATA_WORDS - REQ_COUNT_IDX - 1;
        end
        for (int r = 0; r < req_count; r++) begin
            boot_handshake(r, int'(testdata[REQ_COUNT_IDX + 1 + r]));
        end

        flash_traffic();

        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verif/board_top_checker.sv
// assertions on the reboot handshake and the configuration port, bound into board_top
`timescale 1ns/1ns

module board_top_checker (
    input logic clk_125mhz_int,
    input logic reset,
    input logic boot_req,
    input logic boot_ack,
    input logic icap_csib,
    input logic icap_rdwrb
);

    // consecutive cycles with csib low, saturating
    logic [3:0] low_run;

    always_ff @(posedge clk_125mhz_int) begin
        if (reset) begin
            low_run <= '0;
        end else if (!icap_csib) begin
            if (low_run != 4'hF) begin
                low_run <= low_run + 4'd1;
            end
        end else begin
            low_run <= '0;
        end
    end

    // port is write only
    rdwrb_write_only: assert property (
        @(posedge clk_125mhz_int) disable iff (reset) !icap_rdwrb
    ) else $error("icap_rdwrb went high, the configuration port is write only");

    // one command stream is six words
    csib_burst_len: assert property (
        @(posedge clk_125mhz_int) disable iff (reset) !(!icap_csib && low_run >= 4'd6)
    ) else $error("icap_csib stayed low for more than six cycles");

    ack_outside_burst: assert property (
        @(posedge clk_125mhz_int) disable iff (reset) $rose(boot_ack) |-> icap_csib
    ) else $error("boot_ack rose while icap_csib was low");

    // ack may only drop once the request has been withdrawn
    ack_after_req_drop: assert property (
        @(posedge clk_125mhz_int) disable iff (reset) $fell(boot_ack) |-> !$past(boot_req)
    ) else $error("boot_ack fell while boot_req was still high");

endmodule

bind board_top board_top_checker board_top_checker_i (
    .clk_125mhz_int(clk_125mhz_int),
    .reset(reset),
    .boot_req(boot_req),
    .boot_ack(boot_ack),
    .icap_csib(icap_csib),
    .icap_rdwrb(icap_rdwrb)
);

//--- source/board_top.sv
// board top level joining the boot request sync, the reboot sequencer and the flash pin stage
`timescale 1ns/1ns

module board_top
    import boot_cfg_pkg::*;
    import board_pkg::*;
(
    input  logic       clk_125mhz_int,
    input  logic       reset,

    // boot handshake, req is asynchronous
    input  logic       boot_req,
    output logic       boot_ack,

    // configuration port
    input  logic       icap_avail,
    output logic       icap_csib,
    output logic       icap_rdwrb,
    output cfg_word_t  icap_di,

    // quad SPI flash
    input  qspi_ctrl_t qspi_ctrl,
    output qspi_pin_t  qspi_pins,
    input  qspi_dq_t   qspi_dq_pin,
    output qspi_dq_t   qspi_dq_i
);

    logic req_sync;

    signal_sync #(
        .WIDTH(1)
    ) boot_req_sync_i (
        .clk_125mhz_int(clk_125mhz_int),
        .reset(reset),
        .in(boot_req),
        .out(req_sync)
    );

    icap_reboot_seq reboot_seq_i (
        .clk_125mhz_int(clk_125mhz_int),
        .reset(reset),
        .req_sync(req_sync),
        .icap_avail(icap_avail),
        .boot_ack(boot_ack),
        .icap_csib(icap_csib),
        .icap_rdwrb(icap_rdwrb),
        .icap_di(icap_di)
    );

    flash_pin_stage flash_pin_stage_i (
        .clk_125mhz_int(clk_125mhz_int),
        .reset(reset),
        .qspi_ctrl(qspi_ctrl),
        .qspi_pins(qspi_pins),
        .qspi_dq_pin(qspi_dq_pin),
        .qspi_dq_i(qspi_dq_i)
    );

endmodule

//--- source/flash_pin_stage.sv
// registers flash controller outputs toward the pins and synchronizes the returning data lines
`timescale 1ns/1ns

module flash_pin_stage import board_pkg::*; (
    input  logic       clk_125mhz_int,
    input  logic       reset,
    input  qspi_ctrl_t qspi_ctrl,
    output qspi_pin_t  qspi_pins,
    input  qspi_dq_t   qspi_dq_pin,
    output qspi_dq_t   qspi_dq_i
);

    // one register stage toward the pins
    always_ff @(posedge clk_125mhz_int) begin
        if (reset) begin
            qspi_pins.clk <= 1'b0;
            qspi_pins.cs <= 1'b1;
            qspi_pins.dq_o <= '0;
            qspi_pins.dq_ts <= '1;
        end else begin
            qspi_pins.clk <= qspi_ctrl.clk;
            qspi_pins.cs <= qspi_ctrl.cs;
            qspi_pins.dq_o <= qspi_ctrl.dq_o;
            // enable becomes tristate control
            qspi_pins.dq_ts <= ~qspi_ctrl.dq_oe;
        end
    end

    // data from the pins is asynchronous to this clock
    signal_sync #(
        .WIDTH($bits(qspi_dq_t))
    ) dq_sync_i (
        .clk_125mhz_int(clk_125mhz_int),
        .reset(reset),
        .in(qspi_dq_pin),
        .out(qspi_dq_i)
    );

endmodule

//--- source/icap_reboot_seq.sv
// configuration-port reboot sequencer, sends the IPROG command stream on a req/ack handshake
`timescale 1ns/1ns

module icap_reboot_seq import boot_cfg_pkg::*; (
    input  logic      clk_125mhz_int,
    input  logic      reset,
    input  logic      req_sync,
    input  logic      icap_avail,
    output logic      boot_ack,
    output logic      icap_csib,
    output logic      icap_rdwrb,
    output cfg_word_t icap_di
);

    reboot_state_t state;
    logic          csib_reg;
    logic          ack_reg;
    cfg_word_t     word_reg;

    // state names the word that is on the port in that cycle
    always_ff @(posedge clk_125mhz_int) begin
        if (reset) begin
            state <= IDLE;
            csib_reg <= 1'b1;
            word_reg <= CFG_DUMMY;
            ack_reg <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // word is already the dummy here
                    if (req_sync && icap_avail) begin
                        state <= DUMMY;
                        csib_reg <= 1'b0;
                    end
                end
                DUMMY: begin
                    state <= SYNC;
                    word_reg <= CFG_SYNC;
                end
                SYNC: begin
                    state <= NOOP_A;
                    word_reg <= CFG_NOOP;
                end
                NOOP_A: begin
                    state <= WR_CMD;
                    word_reg <= CFG_WR_CMD;
                end
                WR_CMD: begin
                    state <= IPROG;
                    word_reg <= CFG_IPROG;
                end
                IPROG: begin
                    state <= NOOP_B;
                    word_reg <= CFG_NOOP;
                end
                NOOP_B: begin
                    // end of stream, release the port and acknowledge
                    state <= DONE;
                    csib_reg <= 1'b1;
                    word_reg <= CFG_DUMMY;
                    ack_reg <= 1'b1;
                end
                DONE: begin
                    // hold ack until the requester drops its request
                    if (!req_sync) begin
                        state <= IDLE;
                        ack_reg <= 1'b0;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // port expects each byte bit-reversed, byte order unchanged
    always_comb begin
        for (int b = 0; b < $bits(cfg_word_t) / 8; b++) begin
            for (int i = 0; i < 8; i++) begin
                icap_di[8*b + i] = word_reg[8*b + 7 - i];
            end
        end
    end

    assign icap_csib = csib_reg;
    // write only
    assign icap_rdwrb = 1'b0;
    assign boot_ack = ack_reg;

endmodule

//--- source/signal_sync.sv
// register chain that brings asynchronous levels into the 125 MHz domain, one per bit
`timescale 1ns/1ns

module signal_sync import board_pkg::*; #(
    parameter int WIDTH = 1
) (
    input  logic             clk_125mhz_int,
    input  logic             reset,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    // stage 0 takes the raw input, the last stage is safe to use
    logic [SYNC_STAGES-1:0][WIDTH-1:0] sync_reg;

    always_ff @(posedge clk_125mhz_int) begin
        if (reset) begin
            sync_reg <= '0;
        end else begin
            sync_reg <= {sync_reg[SYNC_STAGES-2:0], in};
        end
    end

    assign out = sync_reg[SYNC_STAGES-1];

endmodule

//--- source/board_pkg.sv
// flash pin types and synchronizer depth, imported by the flash stage, the synchronizer and the top
package board_pkg;

    // depth of every input synchronizer
    localparam int SYNC_STAGES = 2;

    // quad SPI data lines
    typedef logic [3:0] qspi_dq_t;

    // as driven by the flash controller
    typedef struct packed {
        logic     clk;
        logic     cs;
        qspi_dq_t dq_o;
        qspi_dq_t dq_oe;
    } qspi_ctrl_t;

    // as sent to the pins, dq_ts high means the line floats
    typedef struct packed {
        logic     clk;
        logic     cs;
        qspi_dq_t dq_o;
        qspi_dq_t dq_ts;
    } qspi_pin_t;

endpackage

//--- source/boot_cfg_pkg.sv
// configuration-port command words and reboot FSM states, imported by the sequencer and the top
package boot_cfg_pkg;

    // one word on the configuration port
    typedef logic [31:0] cfg_word_t;

    // reboot command stream, sent in this order
    localparam cfg_word_t CFG_DUMMY = 32'hFFFFFFFF;
    localparam cfg_word_t CFG_SYNC = 32'hAA995566;
    // type 1 packet, no-op
    localparam cfg_word_t CFG_NOOP = 32'h20000000;
    // type 1 write, one word to the command register
    localparam cfg_word_t CFG_WR_CMD = 32'h30008001;
    localparam cfg_word_t CFG_IPROG = 32'h0000000F;

    localparam int CFG_SEQ_LEN = 6;

    // one state per command word plus idle and done
    localparam int REBOOT_STATE_W = $clog2(CFG_SEQ_LEN + 2);

    typedef enum logic [REBOOT_STATE_W-1:0] {
        IDLE,
        DUMMY,
        SYNC,
        NOOP_A,
        WR_CMD,
        IPROG,
        NOOP_B,
        DONE
    } reboot_state_t;

endpackage
